// ==== hdl/alu_lane.sv ====
`timescale 1ns/1ps

module alu_lane
    import isa_pkg::*;
    import uarch_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    // From issue
    input  logic      lane_valid,
    output logic      lane_ready,
    input  alu_op_t   lane_op,
    input  phys_tag_t lane_dest,
    input  data_t     lane_a,
    input  data_t     lane_b,

    // To the CDB arbiter
    output logic      res_valid,
    output phys_tag_t res_tag,
    output data_t     res_data,
    input  logic      res_grant
);

    localparam int STEP_W = (MUL_EXEC_CYCLES > 1) ? $clog2(MUL_EXEC_CYCLES) : 1;

    logic              ex_valid;
    alu_op_t           ex_op;
    phys_tag_t         ex_dest;
    data_t             ex_a;
    data_t             ex_b;
    logic [STEP_W-1:0] ex_step;
    data_t             ex_acc;
    logic              ex_done;
    logic              ex_move;
    data_t             mul_part;
    data_t             mul_sum;
    data_t             ex_result;

    // --------------------------------------------------
    // Execute stage
    // --------------------------------------------------

    // One 16-bit half of b per step with the high half shifted into place
    always_comb begin
        if (ex_step == '0) begin
            mul_part = ex_a * data_t'(ex_b[15:0]);
            mul_sum  = mul_part;
        end else begin
            mul_part = ex_a * data_t'(ex_b[31:16]);
            mul_sum  = ex_acc + (mul_part << 16);
        end
    end

    always_comb begin
        case (ex_op)
            OP_ADD:  ex_result = ex_a + ex_b;
            OP_SUB:  ex_result = ex_a - ex_b;
            OP_AND:  ex_result = ex_a & ex_b;
            OP_OR:   ex_result = ex_a | ex_b;
            OP_XOR:  ex_result = ex_a ^ ex_b;
            OP_SLL:  ex_result = ex_a << ex_b[4:0];
            OP_SLT:  ex_result = data_t'($signed(ex_a) < $signed(ex_b));
            default: ex_result = mul_sum;
        endcase
    end

    assign ex_done = ex_valid &&
                     (ex_step == STEP_W'(((ex_op == OP_MUL) ? MUL_EXEC_CYCLES
                                                            : SIMPLE_EXEC_CYCLES) - 1));

    // Advance only into a free or draining result stage
    assign ex_move    = ex_done && (!res_valid || res_grant);
    assign lane_ready = !ex_valid || ex_move;

    always_ff @(posedge clock) begin
        if (reset) begin
            ex_valid <= 1'b0;
            ex_step  <= '0;
        end else if (lane_valid && lane_ready) begin
            ex_valid <= 1'b1;
            ex_step  <= '0;
        end else if (ex_move) begin
            ex_valid <= 1'b0;
        end else if (ex_valid && !ex_done) begin
            ex_step  <= ex_step + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (lane_valid && lane_ready) begin
            ex_op   <= lane_op;
            ex_dest <= lane_dest;
            ex_a    <= lane_a;
            ex_b    <= lane_b;
        end else if (ex_valid && !ex_done) begin
            ex_acc  <= mul_sum;
        end
    end

    // --------------------------------------------------
    // Result stage
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if (ex_move) begin
            res_valid <= 1'b1;
        end else if (res_grant) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (ex_move) begin
            res_tag  <= ex_dest;
            res_data <= ex_result;
        end
    end

endmodule

// ==== hdl/cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter
    import isa_pkg::*;
    import uarch_pkg::*;
#(
    parameter int NUM_LANES = 4,
    parameter int CDB_SZ    = 2
) (
    input  logic                      clock,
    input  logic                      reset,

    // Held lane results
    input  logic      [NUM_LANES-1:0] res_valid,
    input  phys_tag_t [NUM_LANES-1:0] res_tag,
    input  data_t     [NUM_LANES-1:0] res_data,
    output logic      [NUM_LANES-1:0] res_grant,

    // Bus slots
    output logic      [CDB_SZ-1:0]    cdb_valid,
    output phys_tag_t [CDB_SZ-1:0]    cdb_tag,
    output data_t     [CDB_SZ-1:0]    cdb_data
);

    localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [LANE_W-1:0] ptr;
    logic [LANE_W-1:0] last_lane;
    logic [LANE_W-1:0] next_ptr;

    // --------------------------------------------------
    // Slot fill from the rotating pointer
    // --------------------------------------------------

    always_comb begin
        int n_slot;
        int idx;
        res_grant = '0;
        cdb_valid = '0;
        cdb_tag   = '0;
        cdb_data  = '0;
        last_lane = ptr;
        n_slot    = 0;
        for (int k = 0; k < NUM_LANES; k++) begin
            idx = (int'(ptr) + k) % NUM_LANES;
            if (res_valid[idx] && n_slot < CDB_SZ) begin
                res_grant[idx]    = 1'b1;
                cdb_valid[n_slot] = 1'b1;
                cdb_tag[n_slot]   = res_tag[idx];
                cdb_data[n_slot]  = res_data[idx];
                last_lane         = LANE_W'(idx);
                n_slot            = n_slot + 1;
            end
        end
    end

    // Just past the last lane granted
    assign next_ptr = (int'(last_lane) == NUM_LANES - 1) ? '0 : last_lane + 1'b1;

    always_ff @(posedge clock) begin
        if (reset) begin
            ptr <= '0;
        end else if (|res_grant) begin
            ptr <= next_ptr;
        end
    end

endmodule

// ==== hdl/exec_cluster.sv ====
`timescale 1ns/1ps

module exec_cluster
    import isa_pkg::*;
    import uarch_pkg::*;
#(
    parameter int NUM_LANES = 4,
    parameter int CDB_SZ    = 2
) (
    input  logic                   clock,
    input  logic                   reset,

    input  logic                   issue_valid,
    output logic                   issue_ready,
    input  alu_op_t                issue_op,
    input  phys_tag_t              issue_dest,
    input  phys_tag_t              issue_src1,
    input  phys_tag_t              issue_src2,

    // Completions, one set per CDB slot
    output logic      [CDB_SZ-1:0] done_valid,
    output phys_tag_t [CDB_SZ-1:0] done_tag,
    output data_t     [CDB_SZ-1:0] done_data
);

    phys_tag_t [1:0]           rd_tag;
    data_t     [1:0]           rd_data;

    logic      [NUM_LANES-1:0] lane_ready;
    logic      [NUM_LANES-1:0] lane_valid;
    alu_op_t                   lane_op;
    phys_tag_t                 lane_dest;
    data_t                     lane_a;
    data_t                     lane_b;

    logic      [NUM_LANES-1:0] res_valid;
    phys_tag_t [NUM_LANES-1:0] res_tag;
    data_t     [NUM_LANES-1:0] res_data;
    logic      [NUM_LANES-1:0] res_grant;

    logic      [CDB_SZ-1:0]    cdb_valid;
    phys_tag_t [CDB_SZ-1:0]    cdb_tag;
    data_t     [CDB_SZ-1:0]    cdb_data;

    issue_dispatch #(.NUM_LANES(NUM_LANES), .CDB_SZ(CDB_SZ)) u_issue_dispatch (
        .clock, .reset,
        .issue_valid, .issue_ready, .issue_op, .issue_dest, .issue_src1, .issue_src2,
        .rd_tag, .rd_data,
        .cdb_valid, .cdb_tag,
        .lane_ready, .lane_valid, .lane_op, .lane_dest, .lane_a, .lane_b
    );

    regfile #(.CDB_SZ(CDB_SZ)) u_regfile (
        .clock, .reset,
        .rd_tag, .rd_data,
        .cdb_valid, .cdb_tag, .cdb_data
    );

    // --------------------------------------------------
    // Execution lanes
    // --------------------------------------------------

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        alu_lane u_alu_lane (
            .clock      (clock),
            .reset      (reset),
            .lane_valid (lane_valid[i]),
            .lane_ready (lane_ready[i]),
            .lane_op    (lane_op),
            .lane_dest  (lane_dest),
            .lane_a     (lane_a),
            .lane_b     (lane_b),
            .res_valid  (res_valid[i]),
            .res_tag    (res_tag[i]),
            .res_data   (res_data[i]),
            .res_grant  (res_grant[i])
        );
    end

    cdb_arbiter #(.NUM_LANES(NUM_LANES), .CDB_SZ(CDB_SZ)) u_cdb_arbiter (
        .clock, .reset,
        .res_valid, .res_tag, .res_data, .res_grant,
        .cdb_valid, .cdb_tag, .cdb_data
    );

    assign done_valid = cdb_valid;
    assign done_tag   = cdb_tag;
    assign done_data  = cdb_data;

endmodule

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

    // --------------------------------------------------
    // Data path
    // --------------------------------------------------

    parameter int DATA_WIDTH = 32;

    typedef logic [DATA_WIDTH-1:0] data_t;

    // --------------------------------------------------
    // ALU operations
    // --------------------------------------------------

    // Encoding seen on the issue port and carried down to the lanes
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        // Bitwise exclusive or
        OP_XOR = 3'd4,
        // Left shift by the low 5 bits of b
        OP_SLL = 3'd5,
        // Signed compare, result is 0 or 1
        OP_SLT = 3'd6,
        // Low 32 bits of the product, multi-cycle
        OP_MUL = 3'd7
    } alu_op_t;

endpackage

// ==== hdl/issue_dispatch.sv ====
`timescale 1ns/1ps

module issue_dispatch
    import isa_pkg::*;
    import uarch_pkg::*;
#(
    parameter int NUM_LANES = 4,
    parameter int CDB_SZ    = 2
) (
    input  logic                      clock,
    input  logic                      reset,

    // In-order issue port
    input  logic                      issue_valid,
    output logic                      issue_ready,
    input  alu_op_t                   issue_op,
    input  phys_tag_t                 issue_dest,
    input  phys_tag_t                 issue_src1,
    input  phys_tag_t                 issue_src2,

    // Register file read
    output phys_tag_t [1:0]           rd_tag,
    input  data_t     [1:0]           rd_data,

    // CDB broadcast
    input  logic      [CDB_SZ-1:0]    cdb_valid,
    input  phys_tag_t [CDB_SZ-1:0]    cdb_tag,

    // Lane hand-off, payload shared by all lanes
    input  logic      [NUM_LANES-1:0] lane_ready,
    output logic      [NUM_LANES-1:0] lane_valid,
    output alu_op_t                   lane_op,
    output phys_tag_t                 lane_dest,
    output data_t                     lane_a,
    output data_t                     lane_b
);

    logic [NUM_PHYS_REGS-1:0] busy;
    logic [NUM_PHYS_REGS-1:0] busy_set;
    logic [NUM_PHYS_REGS-1:0] busy_clr;
    logic                     active;
    logic                     src1_ok;
    logic                     src2_ok;
    logic                     dest_ok;
    logic                     lane_found;
    logic [NUM_LANES-1:0]     lane_sel;
    logic                     issue_fire;

    // --------------------------------------------------
    // Hazard checks
    // --------------------------------------------------

    always_comb begin
        busy_clr = '0;
        for (int s = 0; s < CDB_SZ; s++) begin
            if (cdb_valid[s]) begin
                busy_clr[cdb_tag[s]] = 1'b1;
            end
        end
    end

    // Source usable if zero, not busy, or on the CDB right now
    assign src1_ok = (issue_src1 == '0) || !busy[issue_src1] || busy_clr[issue_src1];
    assign src2_ok = (issue_src2 == '0) || !busy[issue_src2] || busy_clr[issue_src2];

    // WAW guard
    assign dest_ok = !busy[issue_dest];

    // Lowest-index ready lane
    always_comb begin
        lane_found = 1'b0;
        lane_sel   = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (lane_ready[i] && !lane_found) begin
                lane_sel[i] = 1'b1;
                lane_found  = 1'b1;
            end
        end
    end

    assign issue_ready = active && src1_ok && src2_ok && dest_ok && lane_found;
    assign issue_fire  = issue_valid && issue_ready;

    // --------------------------------------------------
    // Operand read and hand-off
    // --------------------------------------------------

    assign rd_tag[0] = issue_src1;
    assign rd_tag[1] = issue_src2;

    assign lane_valid = issue_fire ? lane_sel : '0;
    assign lane_op    = issue_op;
    assign lane_dest  = issue_dest;
    assign lane_a     = rd_data[0];
    assign lane_b     = rd_data[1];

    // --------------------------------------------------
    // Busy table
    // --------------------------------------------------

    always_comb begin
        busy_set = '0;
        if (issue_fire && issue_dest != '0) begin
            busy_set[issue_dest] = 1'b1;
        end
    end

    // Set wins over a clear on the same edge
    always_ff @(posedge clock) begin
        if (reset) begin
            busy   <= '0;
            active <= 1'b0;
        end else begin
            busy   <= (busy & ~busy_clr) | busy_set;
            active <= 1'b1;
        end
    end

endmodule

// ==== hdl/regfile.sv ====
`timescale 1ns/1ps

module regfile
    import isa_pkg::*;
    import uarch_pkg::*;
#(
    parameter int CDB_SZ = 2
) (
    input  logic                   clock,
    input  logic                   reset,

    // Two combinational read ports, 0 for src1 and 1 for src2
    input  phys_tag_t [1:0]        rd_tag,
    output data_t     [1:0]        rd_data,

    // Writes from the common data bus
    input  logic      [CDB_SZ-1:0] cdb_valid,
    input  phys_tag_t [CDB_SZ-1:0] cdb_tag,
    input  data_t     [CDB_SZ-1:0] cdb_data
);

    data_t regs [NUM_PHYS_REGS];

    // --------------------------------------------------
    // Read with CDB forwarding
    // --------------------------------------------------

    function automatic data_t read_forward(phys_tag_t tag);
        data_t value;
        logic  hit;
        value = '0;
        hit   = 1'b0;
        // Lowest slot wins, though tags on the bus never repeat
        for (int s = 0; s < CDB_SZ; s++) begin
            if (!hit && cdb_valid[s] && cdb_tag[s] == tag) begin
                value = cdb_data[s];
                hit   = 1'b1;
            end
        end
        if (!hit && tag != '0) begin
            value = regs[tag];
        end
        return value;
    endfunction

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            rd_data[p] = read_forward(rd_tag[p]);
        end
    end

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int s = 0; s < CDB_SZ; s++) begin
                // Writes to tag 0 are dropped
                if (cdb_valid[s] && cdb_tag[s] != '0) begin
                    regs[cdb_tag[s]] <= cdb_data[s];
                end
            end
        end
    end

endmodule

// ==== hdl/uarch_pkg.sv ====
package uarch_pkg;

    // --------------------------------------------------
    // Physical register space
    // --------------------------------------------------

    parameter int NUM_PHYS_REGS = 64;

    parameter int TAG_WIDTH = $clog2(NUM_PHYS_REGS);

    // Tag 0 names the zero register
    typedef logic [TAG_WIDTH-1:0] phys_tag_t;

    // --------------------------------------------------
    // Lane timing
    // --------------------------------------------------

    // Execute cycles spent by MUL, one per 16-bit half of b
    parameter int MUL_EXEC_CYCLES = 2;

    // Execute cycles spent by every other operation
    parameter int SIMPLE_EXEC_CYCLES = 1;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -Wno-fatal --top-module tb_exec_cluster -f vlog.f \
    || { echo "Build failed"; exit 1; }
out=$(./obj_dir/Vtb_exec_cluster)
echo "$out"
echo "$out" | grep -qx "=== PASS ===" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== sim/tb_exec_cluster.sv ====
`timescale 1ns/1ps

module tb_exec_cluster
    import isa_pkg::*;
    import uarch_pkg::*;
();

    localparam int NUM_LANES = 4;
    localparam int CDB_SZ    = 2;
    localparam int NUM_INSTR = 2000;
    localparam int WATCHDOG_CYCLES =
        16 + NUM_INSTR * (3 + MUL_EXEC_CYCLES + NUM_LANES) + 500;
    // At most two instructions per lane still in flight
    localparam int DRAIN_CYCLES = 2 * NUM_LANES * (3 + MUL_EXEC_CYCLES + NUM_LANES);

    logic                   clock;
    logic                   reset;
    logic                   issue_valid;
    logic                   issue_ready;
    alu_op_t                issue_op;
    phys_tag_t              issue_dest;
    phys_tag_t              issue_src1;
    phys_tag_t              issue_src2;
    logic      [CDB_SZ-1:0] done_valid;
    phys_tag_t [CDB_SZ-1:0] done_tag;
    data_t     [CDB_SZ-1:0] done_data;

    int        seed        = 32'hc252;
    int        cycle       = 0;
    int        issue_count = 0;
    int        done_count  = 0;
    logic      accepted    = 1'b0;
    phys_tag_t last_dest   = '0;

    // Reference model indexed by physical tag
    data_t model_regs [NUM_PHYS_REGS];
    data_t expect_val [NUM_PHYS_REGS];
    logic  pending    [NUM_PHYS_REGS];
    logic  pend_mul   [NUM_PHYS_REGS];
    logic  pend_zero  [NUM_PHYS_REGS];
    int    issue_cyc  [NUM_PHYS_REGS];

    exec_cluster #(.NUM_LANES(NUM_LANES), .CDB_SZ(CDB_SZ)) u_exec_cluster (
        .clock, .reset,
        .issue_valid, .issue_ready, .issue_op, .issue_dest, .issue_src1, .issue_src2,
        .done_valid, .done_tag, .done_data
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
    end

    // --------------------------------------------------
    // Model and helpers
    // --------------------------------------------------

    function automatic data_t model_exec(alu_op_t op, data_t a, data_t b);
        logic [63:0] product;
        product = 64'(a) * 64'(b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return product[31:0];
        endcase
    endfunction

    // MUL about three times in eight
    function automatic alu_op_t pick_op();
        if ($unsigned($random(seed)) % 8 < 3) begin
            return OP_MUL;
        end
        return alu_op_t'($unsigned($random(seed)) % 7);
    endfunction

    // Some sources follow the last destination to build chains
    function automatic phys_tag_t pick_src();
        if ($unsigned($random(seed)) % 4 == 0) begin
            return last_dest;
        end
        return phys_tag_t'($unsigned($random(seed)) % NUM_PHYS_REGS);
    endfunction

    task automatic report_mismatch(string test, data_t expected, data_t actual);
        $display("ERROR test=%s expected=%h actual=%h", test, expected, actual);
        $display("=== FAIL ===");
    endtask

    task automatic report_problem(string what);
        $display("%s", what);
        $display("=== FAIL ===");
    endtask

    task automatic check_completion(phys_tag_t tag, data_t value);
        int min_lat;
        min_lat = pend_mul[tag] ? MUL_EXEC_CYCLES + 1 : 2;
        assert (pending[tag]) else begin
            report_problem($sformatf("Tag %0d completed with no instruction pending", tag));
            $fatal(1, "unexpected completion");
        end
        assert (value == expect_val[tag]) else begin
            report_mismatch($sformatf("%s[tag %0d]", pend_zero[tag] ? "zero_src" : "cdb_data",
                            tag), expect_val[tag], value);
            $fatal(1, "wrong result");
        end
        assert (cycle - issue_cyc[tag] >= min_lat) else begin
            report_problem($sformatf("Tag %0d completed %0d cycles after issue, minimum is %0d",
                                     tag, cycle - issue_cyc[tag], min_lat));
            $fatal(1, "result too early");
        end
        pending[tag] = 1'b0;
        done_count++;
    endtask

    task automatic record_issue();
        data_t a;
        data_t b;
        a = (issue_src1 == '0) ? '0 : model_regs[issue_src1];
        b = (issue_src2 == '0) ? '0 : model_regs[issue_src2];
        assert (!pending[issue_dest]) else begin
            report_problem($sformatf("Tag %0d issued again while still pending", issue_dest));
            $fatal(1, "tag reuse");
        end
        expect_val[issue_dest] = model_exec(issue_op, a, b);
        model_regs[issue_dest] = expect_val[issue_dest];
        pending[issue_dest]    = 1'b1;
        pend_mul[issue_dest]   = (issue_op == OP_MUL);
        pend_zero[issue_dest]  = (issue_src1 == '0) || (issue_src2 == '0);
        issue_cyc[issue_dest]  = cycle;
        issue_count++;
        accepted = 1'b1;
    endtask

    // --------------------------------------------------
    // Monitor sampling at the falling edge
    // --------------------------------------------------

    initial begin : monitor
        for (int t = 0; t < NUM_PHYS_REGS; t++) begin
            model_regs[t] = '0;
            pending[t]    = 1'b0;
            pend_mul[t]   = 1'b0;
            pend_zero[t]  = 1'b0;
        end
        forever begin
            @(negedge clock);
            cycle++;
            if (reset) begin
                assert (!issue_ready) else begin
                    report_problem("issue_ready was high during reset");
                    $fatal(1, "ready in reset");
                end
            end
            if (issue_count == 0) begin
                assert (done_valid == '0) else begin
                    report_problem("done_valid was high before any instruction issued");
                    $fatal(1, "early done");
                end
            end
            for (int s = 0; s < CDB_SZ; s++) begin
                if (done_valid[s]) begin
                    check_completion(done_tag[s], done_data[s]);
                end
            end
            if (!reset && issue_valid && issue_ready) begin
                record_issue();
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        report_problem($sformatf("Timeout with %0d of %0d instructions completed",
                                 done_count, NUM_INSTR));
        $fatal(1, "watchdog timeout");
    end

    // --------------------------------------------------
    // Stimulus driven 1 ns after the rising edge
    // --------------------------------------------------

    initial begin : stimulus
        int left;
        int waited;
        issue_valid = 1'b0;
        issue_op    = OP_ADD;
        issue_dest  = '0;
        issue_src1  = '0;
        issue_src2  = '0;
        while (reset !== 1'b0) @(posedge clock);
        while (issue_count < NUM_INSTR) begin
            @(posedge clock);
            #1;
            if (!issue_valid || accepted) begin
                accepted = 1'b0;
                if (issue_count < NUM_INSTR && $unsigned($random(seed)) % 4 != 0) begin
                    issue_op    = pick_op();
                    issue_src1  = pick_src();
                    issue_src2  = pick_src();
                    issue_dest  = phys_tag_t'(1 + $unsigned($random(seed)) % (NUM_PHYS_REGS - 1));
                    last_dest   = issue_dest;
                    issue_valid = 1'b1;
                end else begin
                    issue_valid = 1'b0;
                end
            end
        end
        issue_valid = 1'b0;

        // Drain and then watch for stray completions
        waited = 0;
        while (done_count < issue_count && waited < DRAIN_CYCLES) begin
            @(posedge clock);
            waited++;
        end
        repeat (20) @(posedge clock);
        left = 0;
        for (int t = 0; t < NUM_PHYS_REGS; t++) begin
            if (pending[t]) begin
                left++;
            end
        end
        assert (left == 0) else begin
            report_mismatch("pending_empty", 32'd0, data_t'(left));
            $fatal(1, "pending left");
        end
        assert (done_count == issue_count) else begin
            report_mismatch("completion_count", data_t'(issue_count), data_t'(done_count));
            $fatal(1, "count mismatch");
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== vlog.f ====
hdl/isa_pkg.sv
hdl/uarch_pkg.sv
hdl/regfile.sv
hdl/issue_dispatch.sv
hdl/alu_lane.sv
hdl/cdb_arbiter.sv
hdl/exec_cluster.sv
sim/tb_exec_cluster.sv
